/* compile.f */
+incdir+src
src/frogger_pkg.sv
src/game_control.sv
src/frog_mover.sv
src/lane_traffic.sv
src/hit_detector.sv
src/frogger_core.sv
bench/tb_frogger_core.sv

/* Makefile */
TOOL     = verilator
FLAGS    = --binary --timing --assert -Wno-fatal
TOP      = tb_frogger_core
FILELIST = compile.f
OBJ_DIR  = obj_dir
LOG      = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench, result taken from $(LOG)"
	@echo "  clean  remove the build directory and the log"
	@echo "  help   list these targets"

test:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR) -o $(TOP)
	./$(OBJ_DIR)/$(TOP) | tee $(LOG)
	grep -q -F "** PASS **" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* bench/tb_frogger_core.sv */
/*
 * Testbench for the frog game core. Drives buttons and start, runs a
 * cycle model of frog, lanes, hits and lives, and compares every cycle.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module tb_frogger_core;

    import frogger_pkg::*;

    localparam int CLK_PERIOD   = 20;
    localparam int TEST_CYCLES  = 12000;
    localparam int WATCHDOG_NS  = (TEST_CYCLES + 2000) * CLK_PERIOD;
    localparam int HOLDOFF      = 8;
    localparam int LANE0_PERIOD = 4;
    localparam int LANE0_STEP   = 32;
    localparam int LANE1_PERIOD = 6;
    localparam int LANE1_STEP   = -32;
    localparam int TILE         = `TILE_SIZE;
    localparam int SCREEN_W     = `H_VISIBLE;
    localparam int X_MAX        = SCREEN_W - TILE;
    localparam int Y_MAX        = `V_VISIBLE - TILE;
    localparam logic [3:0] BTN_UP    = 4'b1000;
    localparam logic [3:0] BTN_DOWN  = 4'b0100;
    localparam logic [3:0] BTN_LEFT  = 4'b0010;
    localparam logic [3:0] BTN_RIGHT = 4'b0001;

    logic i_Clk = 1'b0;
    logic i_reset;
    logic i_start;
    logic i_up;
    logic i_down;
    logic i_left;
    logic i_right;

    game_state_t         o_state;
    logic [1:0]          o_lives;
    logic [3:0]          o_level;
    logic [`SCORE_W-1:0] o_score;
    logic [9:0]          o_frog_x;
    logic [8:0]          o_frog_y;
    logic                o_draw_frog;
    logic [19:0]         o_lane0_x;
    logic [19:0]         o_lane1_x;

    // Model state runs one clock ahead of the DUT between edges
    game_state_t m_state;
    int          tb_lives;
    int          m_level;
    int          m_x;
    int          m_y;
    int          m_score;
    logic        m_level_up;
    logic        m_prev;
    int          m_hold;
    logic        m_hit;
    int          m_mask;
    int          m_tick0;
    int          m_tick1;
    int          m_car0 [2];
    int          m_car1 [2];
    logic        model_ok = 1'b0;

    int     checks = 0;
    int     errors = 0;
    integer seed   = 42026;

    frogger_core #(
        .MOVE_HOLDOFF(HOLDOFF),
        .LANE0_PERIOD(LANE0_PERIOD), .LANE0_STEP(LANE0_STEP),
        .LANE1_PERIOD(LANE1_PERIOD), .LANE1_STEP(LANE1_STEP)
    ) DUT (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_start(i_start),
        .i_up(i_up), .i_down(i_down), .i_left(i_left), .i_right(i_right),
        .o_state(o_state), .o_lives(o_lives), .o_level(o_level), .o_score(o_score),
        .o_frog_x(o_frog_x), .o_frog_y(o_frog_y), .o_draw_frog(o_draw_frog),
        .o_lane0_x(o_lane0_x), .o_lane1_x(o_lane1_x)
    );

    always #(CLK_PERIOD / 2) i_Clk = ~i_Clk;

    task automatic check_val(input string name, input logic [31:0] got,
                             input logic [31:0] expected);
        checks++;
        if (got !== expected)
        begin
            errors++;
            $display("error at %0d ns: %s got %0d expected %0d", $time, name, got, expected);
        end
    endtask

    // Result is {valid, scored, x[9:0], y[8:0]} for one button pattern
    function automatic logic [20:0] expect_move(input int x, input int y,
                                                input logic [3:0] btn);
        int   nx;
        int   ny;
        logic ok;
        logic scored;
        nx = x;
        ny = y;
        ok = 1'b1;
        scored = 1'b0;
        case (btn)
            BTN_UP:
            begin
                ok = (y > 0);
                // Stepping off the top row counts as a crossing
                if (y <= TILE)
                begin
                    nx = `FROG_X_BASE;
                    ny = `FROG_Y_BASE;
                    scored = 1'b1;
                end
                else
                begin
                    ny = y - TILE;
                end
            end
            BTN_DOWN:
            begin
                ok = (y + TILE <= Y_MAX);
                ny = y + TILE;
            end
            BTN_LEFT:
            begin
                ok = (x >= TILE);
                nx = x - TILE;
            end
            BTN_RIGHT:
            begin
                ok = (x + TILE <= X_MAX);
                nx = x + TILE;
            end
            default: ok = 1'b0;
        endcase
        return {ok, scored, 10'(nx), 9'(ny)};
    endfunction

    function automatic int expect_lane(input int x, input int step);
        return (x + step + SCREEN_W) % SCREEN_W;
    endfunction

    // Two 32 pixel spans on a circular screen
    function automatic logic boxes_overlap(input int fx, input int cx);
        int d;
        d = (fx - cx + SCREEN_W) % SCREEN_W;
        return (d < TILE) || (SCREEN_W - d < TILE);
    endfunction

    // True when no car of the lane reaches column fx soon
    function automatic logic lane_clear(input int fx, input int lane);
        logic ok;
        ok = 1'b1;
        for (int k = 0; k < 2; k++)
        begin
            if (lane == 0 && (fx - m_car0[k] + SCREEN_W) % SCREEN_W < 6 * TILE)
                ok = 1'b0;
            if (lane == 1 && (m_car1[k] - fx + SCREEN_W) % SCREEN_W < 4 * TILE)
                ok = 1'b0;
        end
        return ok;
    endfunction

    task automatic reset_model();
        m_state    = IDLE;
        tb_lives   = 0;
        m_level    = 0;
        m_x        = `FROG_X_BASE;
        m_y        = `FROG_Y_BASE;
        m_score    = 0;
        m_level_up = 1'b0;
        m_prev     = 1'b0;
        m_hold     = 0;
        m_hit      = 1'b0;
        m_mask     = 0;
        m_tick0    = 0;
        m_tick1    = 0;
        for (int k = 0; k < 2; k++)
        begin
            m_car0[k] = k * SCREEN_W / 2;
            m_car1[k] = k * SCREEN_W / 2;
        end
        model_ok = 1'b1;
    endtask

    task automatic step_model();
        logic [3:0]  btn;
        logic [20:0] mv;
        logic        active;
        logic        accept;
        logic        overlap;
        logic        hit_now;
        logic        step0;
        logic        step1;
        btn    = {i_up, i_down, i_left, i_right};
        active = (m_state == ACTIVE);
        mv     = expect_move(m_x, m_y, btn);
        accept = active && mv[20] && !m_prev && (m_hold >= HOLDOFF);
        overlap = 1'b0;
        for (int k = 0; k < 2; k++)
        begin
            if (m_y == `LANE0_Y && boxes_overlap(m_x, m_car0[k]))
                overlap = 1'b1;
            if (m_y == `LANE1_Y && boxes_overlap(m_x, m_car1[k]))
                overlap = 1'b1;
        end
        hit_now = overlap && (m_mask == 0);

        // Game flow and lives
        case (m_state)
            IDLE:
            begin
                if (i_start)
                begin
                    m_state  = ACTIVE;
                    tb_lives = `START_LIVES;
                    m_level  = 0;
                end
            end
            ACTIVE:
            begin
                if (m_hit)
                begin
                    if (tb_lives == 1)
                        m_state = OVER;
                    tb_lives = tb_lives - 1;
                end
                else if (m_level_up)
                begin
                    m_level = m_level + 1;
                end
            end
            default:
            begin
                if (i_start)
                    m_state = IDLE;
            end
        endcase

        // A hit on the frog beats a move
        m_level_up = 1'b0;
        if (m_hit)
        begin
            m_x     = `FROG_X_BASE;
            m_y     = `FROG_Y_BASE;
            m_score = 0;
        end
        else if (accept)
        begin
            m_x = int'(mv[18:9]);
            m_y = int'(mv[8:0]);
            if (mv[19])
            begin
                m_score    = m_score + 1;
                m_level_up = 1'b1;
            end
        end
        if (active)
        begin
            if (accept)
                m_hold = 0;
            else if (m_hold < HOLDOFF)
                m_hold = m_hold + 1;
        end
        m_prev = |btn;

        // Lanes only run in a live game
        if (active)
        begin
            step0   = (m_tick0 == LANE0_PERIOD - 1);
            step1   = (m_tick1 == LANE1_PERIOD - 1);
            m_tick0 = step0 ? 0 : m_tick0 + 1;
            m_tick1 = step1 ? 0 : m_tick1 + 1;
            for (int k = 0; k < 2; k++)
            begin
                if (step0)
                    m_car0[k] = expect_lane(m_car0[k], LANE0_STEP);
                if (step1)
                    m_car1[k] = expect_lane(m_car1[k], LANE1_STEP);
            end
        end

        if (hit_now)
            m_mask = 2;
        else if (m_mask > 0)
            m_mask = m_mask - 1;
        m_hit = hit_now;
    endtask

    task automatic compare_outputs();
        check_val("o_state", o_state, m_state);
        check_val("o_lives", o_lives, tb_lives);
        check_val("o_level", o_level, m_level);
        check_val("o_score", o_score, m_score);
        check_val("o_frog_x", o_frog_x, m_x);
        check_val("o_frog_y", o_frog_y, m_y);
        check_val("o_draw_frog", o_draw_frog, m_state == ACTIVE);
        for (int k = 0; k < 2; k++)
        begin
            check_val($sformatf("o_lane0_x[%0d]", k), o_lane0_x[k*10 +: 10], m_car0[k]);
            check_val($sformatf("o_lane1_x[%0d]", k), o_lane1_x[k*10 +: 10], m_car1[k]);
        end
    endtask

    // Outputs and inputs are both settled at the falling edge
    always @(negedge i_Clk)
    begin
        if (model_ok)
            compare_outputs();
        if (i_reset)
            reset_model();
        else
            step_model();
    end

    task automatic press_btn(input logic [3:0] btn, input int hold, input int gap);
        @(posedge i_Clk);
        {i_up, i_down, i_left, i_right} <= btn;
        repeat (hold) @(posedge i_Clk);
        {i_up, i_down, i_left, i_right} <= 4'b0000;
        repeat (gap) @(posedge i_Clk);
    endtask

    task automatic pulse_start();
        @(posedge i_Clk);
        i_start <= 1'b1;
        @(posedge i_Clk);
        i_start <= 1'b0;
    endtask

    // Walk up and wait below each lane until its cars are far off
    task automatic cross_to_top();
        int lvl;
        lvl = m_level;
        while (m_level == lvl && m_state == ACTIVE)
        begin
            if (m_y == `LANE0_Y + TILE)
            begin
                while (!lane_clear(m_x, 0))
                    @(posedge i_Clk);
            end
            else if (m_y == `LANE1_Y + TILE)
            begin
                while (!lane_clear(m_x, 1))
                    @(posedge i_Clk);
            end
            press_btn(BTN_UP, 1, 10);
        end
    endtask

    initial
    begin
        int         tries;
        int         r;
        logic [3:0] btn;
        i_reset = 1'b1;
        i_start = 1'b0;
        i_up    = 1'b0;
        i_down  = 1'b0;
        i_left  = 1'b0;
        i_right = 1'b0;
        repeat (8) @(posedge i_Clk);
        i_reset <= 1'b0;

        // Lanes stay frozen while idle
        repeat (6) @(posedge i_Clk);
        pulse_start();
        @(negedge i_Clk);
        check_val("o_state", o_state, ACTIVE);
        check_val("o_lives", o_lives, 3);
        repeat (10) @(posedge i_Clk);

        press_btn(BTN_UP, 1, 10);
        press_btn(BTN_DOWN, 1, 10);
        press_btn(BTN_DOWN, 1, 10);
        press_btn(BTN_UP | BTN_LEFT, 1, 10);
        press_btn(BTN_LEFT, 20, 10);
        // Second press lands inside the hold-off window
        press_btn(BTN_LEFT, 1, 2);
        press_btn(BTN_LEFT, 1, 10);
        repeat (12) press_btn(BTN_LEFT, 1, 10);
        @(negedge i_Clk);
        check_val("o_frog_x", o_frog_x, 0);
        repeat (21) press_btn(BTN_RIGHT, 1, 10);
        @(negedge i_Clk);
        check_val("o_frog_x", o_frog_x, X_MAX);

        cross_to_top();
        @(negedge i_Clk);
        check_val("o_score", o_score, 1);
        check_val("o_level", o_level, 1);

        // Random walk into traffic until the lives run out
        tries = 0;
        while (m_state != OVER && tries < 400)
        begin
            r = {$random(seed)} % 8;
            if (r < 6)
                btn = BTN_UP;
            else if (r == 6)
                btn = BTN_LEFT;
            else
                btn = BTN_RIGHT;
            press_btn(btn, 1, 9 + {$random(seed)} % 16);
            tries++;
        end
        @(negedge i_Clk);
        check_val("o_state", o_state, OVER);
        press_btn(BTN_UP, 1, 30);

        pulse_start();
        @(negedge i_Clk);
        check_val("o_state", o_state, IDLE);
        pulse_start();
        @(negedge i_Clk);
        check_val("o_state", o_state, ACTIVE);
        check_val("o_lives", o_lives, 3);
        repeat (20) @(posedge i_Clk);

        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0)
        begin
            $display("** PASS **");
        end
        else
        begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("timeout: the test sequence did not finish in time");
        $display("** FAIL **");
        $finish;
    end

endmodule

`default_nettype wire

/* src/frogger_core.sv */
/*
 * Gameplay core top level. Ties game control, the frog, two car lanes
 * and the hit detector together and exports positions for a renderer.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module frogger_core #(
    parameter int MOVE_HOLDOFF = 3125000,
    parameter int LANE0_PERIOD = 4,
    parameter int LANE0_STEP   = 32,
    parameter int LANE1_PERIOD = 6,
    parameter int LANE1_STEP   = -32
)(
    input  wire                           i_Clk,
    input  wire                           i_reset,
    input  wire                           i_start,
    input  wire                           i_up,
    input  wire                           i_down,
    input  wire                           i_left,
    input  wire                           i_right,
    output frogger_pkg::game_state_t      o_state,
    output logic [1:0]                    o_lives,
    output logic [3:0]                    o_level,
    output logic [`SCORE_W-1:0]           o_score,
    output logic [9:0]                    o_frog_x,
    output logic [8:0]                    o_frog_y,
    output logic                          o_draw_frog,
    output logic [`CARS_PER_LANE*10-1:0]  o_lane0_x,
    output logic [`CARS_PER_LANE*10-1:0]  o_lane1_x
);

    logic game_active;
    logic hit;
    logic level_up;

    game_control u_control (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_start(i_start),
        .i_hit(hit), .i_level_up(level_up),
        .o_state(o_state), .o_game_active(game_active),
        .o_lives(o_lives), .o_level(o_level)
    );

    frog_mover #(.MOVE_HOLDOFF(MOVE_HOLDOFF)) u_frog (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_game_active(game_active),
        .i_up(i_up), .i_down(i_down), .i_left(i_left), .i_right(i_right),
        .i_hit(hit),
        .o_frog_x(o_frog_x), .o_frog_y(o_frog_y), .o_score(o_score),
        .o_level_up(level_up), .o_draw_frog(o_draw_frog)
    );

    // Lower lane runs right, upper lane runs left and slower
    lane_traffic #(.LANE_PERIOD(LANE0_PERIOD), .LANE_STEP(LANE0_STEP)) u_lane0 (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_game_active(game_active),
        .o_car_x(o_lane0_x)
    );

    lane_traffic #(.LANE_PERIOD(LANE1_PERIOD), .LANE_STEP(LANE1_STEP)) u_lane1 (
        .i_Clk(i_Clk), .i_reset(i_reset), .i_game_active(game_active),
        .o_car_x(o_lane1_x)
    );

    hit_detector u_hit (
        .i_Clk(i_Clk), .i_reset(i_reset),
        .i_frog_x(o_frog_x), .i_frog_y(o_frog_y),
        .i_lane0_x(o_lane0_x), .i_lane1_x(o_lane1_x),
        .o_hit(hit)
    );

endmodule

`default_nettype wire

/* src/hit_detector.sv */
/*
 * Collision check between the frog and every car of both lanes.
 * Registered hit pulse, blanked for two cycles after each hit.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module hit_detector #(
    parameter logic [8:0] LANE0_ROW = 9'(`LANE0_Y),
    parameter logic [8:0] LANE1_ROW = 9'(`LANE1_Y)
)(
    input  wire                           i_Clk,
    input  wire                           i_reset,
    input  wire [9:0]                     i_frog_x,
    input  wire [8:0]                     i_frog_y,
    input  wire [`CARS_PER_LANE*10-1:0]   i_lane0_x,
    input  wire [`CARS_PER_LANE*10-1:0]   i_lane1_x,
    output logic                          o_hit
);

    localparam int CARS = `CARS_PER_LANE;

    logic       any_overlap;
    logic [1:0] mask_cnt;

    // Distance modulo screen width, close on either side means overlap
    function automatic logic boxes_meet(input logic [9:0] fx, input logic [9:0] cx);
        logic [10:0] diff;
        diff = {1'b0, fx} + 11'd640 - {1'b0, cx};
        if (diff >= 11'd640)
        begin
            diff = diff - 11'd640;
        end
        return (diff < 11'(`TILE_SIZE)) || (diff > 11'd640 - 11'(`TILE_SIZE));
    endfunction

    always_comb
    begin
        any_overlap = 1'b0;
        for (int k = 0; k < CARS; k++)
        begin
            if ((i_frog_y == LANE0_ROW) && boxes_meet(i_frog_x, i_lane0_x[k*10 +: 10]))
                any_overlap = 1'b1;
            if ((i_frog_y == LANE1_ROW) && boxes_meet(i_frog_x, i_lane1_x[k*10 +: 10]))
                any_overlap = 1'b1;
        end
    end

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            o_hit    <= 1'b0;
            mask_cnt <= 2'd0;
        end
        else
        begin
            o_hit <= any_overlap && (mask_cnt == 2'd0);
            // Frog is still on the lane until the respawn lands
            if (any_overlap && (mask_cnt == 2'd0))
                mask_cnt <= 2'd2;
            else if (mask_cnt != 2'd0)
                mask_cnt <= mask_cnt - 2'd1;
        end
    end

endmodule

`default_nettype wire

/* src/lane_traffic.sv */
/*
 * One lane of cars. Every car moves by LANE_STEP pixels once per
 * LANE_PERIOD active cycles and wraps around the screen width.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module lane_traffic #(
    parameter int LANE_PERIOD = 4,
    parameter int LANE_STEP   = 32
)(
    input  wire                            i_Clk,
    input  wire                            i_reset,
    input  wire                            i_game_active,
    output logic [`CARS_PER_LANE*10-1:0]   o_car_x
);

    localparam int         CARS    = `CARS_PER_LANE;
    localparam int         TICK_W  = $clog2(LANE_PERIOD + 1);
    localparam logic [TICK_W-1:0] TICK_LAST = TICK_W'(LANE_PERIOD - 1);
    localparam logic [9:0] SPACING = `H_VISIBLE / 10'(CARS);

    logic [TICK_W-1:0] tick_cnt;
    logic              step_now;

    // Signed add, then fold back into 0..639
    function automatic logic [9:0] wrap_step(input logic [9:0] x);
        logic signed [11:0] sum;
        sum = $signed({2'b00, x}) + $signed(12'(LANE_STEP));
        if (sum >= 12'sd640)
        begin
            sum = sum - 12'sd640;
        end
        else if (sum < 12'sd0)
        begin
            sum = sum + 12'sd640;
        end
        return sum[9:0];
    endfunction

    assign step_now = i_game_active && (tick_cnt == TICK_LAST);

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            tick_cnt <= '0;
            // Cars start evenly spread over the lane
            for (int k = 0; k < CARS; k++)
            begin
                o_car_x[k*10 +: 10] <= 10'(k) * SPACING;
            end
        end
        else if (i_game_active)
        begin
            if (step_now)
            begin
                tick_cnt <= '0;
                for (int k = 0; k < CARS; k++)
                begin
                    o_car_x[k*10 +: 10] <= wrap_step(o_car_x[k*10 +: 10]);
                end
            end
            else
            begin
                tick_cnt <= tick_cnt + 1'b1;
            end
        end
    end

    for (genvar g = 0; g < CARS; g++)
    begin : g_car_check
        a_car_on_screen : assert property (@(posedge i_Clk) disable iff (i_reset)
            o_car_x[g*10 +: 10] < `H_VISIBLE);
    end

endmodule

`default_nettype wire

/* src/frog_mover.sv */
/*
 * Player frog position. Accepts one tile move per button press after a
 * hold-off, respawns on a hit and scores when the top row is reached.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module frog_mover #(
    parameter int MOVE_HOLDOFF = 3125000
)(
    input  wire                   i_Clk,
    input  wire                   i_reset,
    input  wire                   i_game_active,
    input  wire                   i_up,
    input  wire                   i_down,
    input  wire                   i_left,
    input  wire                   i_right,
    input  wire                   i_hit,
    output logic [9:0]            o_frog_x,
    output logic [8:0]            o_frog_y,
    output logic [`SCORE_W-1:0]   o_score,
    output logic                  o_level_up,
    output logic                  o_draw_frog
);

    import frogger_pkg::*;

    localparam int              CNT_W    = $clog2(MOVE_HOLDOFF + 1);
    localparam logic [CNT_W-1:0] HOLD_MAX = CNT_W'(MOVE_HOLDOFF);
    localparam logic [9:0]      TILE_X   = 10'(`TILE_SIZE);
    localparam logic [8:0]      TILE_Y   = 9'(`TILE_SIZE);
    localparam logic [9:0]      X_LAST   = `H_VISIBLE - TILE_X;
    localparam logic [8:0]      Y_LAST   = 9'(`V_VISIBLE) - TILE_Y;
    localparam logic [9:0]      X_BASE   = 10'(`FROG_X_BASE);
    localparam logic [8:0]      Y_BASE   = 9'(`FROG_Y_BASE);

    logic [3:0]       buttons;
    logic             any_pressed;
    logic             prev_pressed;
    logic [CNT_W-1:0] holdoff_cnt;
    logic             in_bounds;
    logic             accept;
    move_dir_t        move_dir;

    assign buttons     = {i_up, i_down, i_left, i_right};
    assign any_pressed = |buttons;

    // Exactly one button gives a direction, anything else is ignored
    always_comb
    begin
        case (buttons)
            4'b1000: move_dir = UP;
            4'b0100: move_dir = DOWN;
            4'b0010: move_dir = LEFT;
            4'b0001: move_dir = RIGHT;
            default: move_dir = NONE;
        endcase
    end

    // Up is always allowed, the top row turns it into a respawn
    always_comb
    begin
        case (move_dir)
            UP:      in_bounds = (o_frog_y > 9'd0);
            DOWN:    in_bounds = (o_frog_y < Y_LAST);
            LEFT:    in_bounds = (o_frog_x > 10'd0);
            RIGHT:   in_bounds = (o_frog_x < X_LAST);
            default: in_bounds = 1'b0;
        endcase
    end

    assign accept = i_game_active && (move_dir != NONE) && !prev_pressed
                    && (holdoff_cnt == HOLD_MAX) && in_bounds;

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            o_frog_x     <= X_BASE;
            o_frog_y     <= Y_BASE;
            o_score      <= '0;
            o_level_up   <= 1'b0;
            holdoff_cnt  <= '0;
            prev_pressed <= 1'b0;
        end
        else
        begin
            o_level_up   <= 1'b0;
            prev_pressed <= any_pressed;

            if (i_game_active)
            begin
                if (accept)
                begin
                    holdoff_cnt <= '0;
                end
                else if (holdoff_cnt < HOLD_MAX)
                begin
                    holdoff_cnt <= holdoff_cnt + 1'b1;
                end
            end

            // A hit wins over any move in the same cycle
            if (i_hit)
            begin
                o_frog_x <= X_BASE;
                o_frog_y <= Y_BASE;
                o_score  <= '0;
            end
            else if (accept)
            begin
                case (move_dir)
                    UP:
                    begin
                        if (o_frog_y <= TILE_Y)
                        begin
                            o_frog_x   <= X_BASE;
                            o_frog_y   <= Y_BASE;
                            o_score    <= o_score + 1'b1;
                            o_level_up <= 1'b1;
                        end
                        else
                        begin
                            o_frog_y <= o_frog_y - TILE_Y;
                        end
                    end
                    DOWN:    o_frog_y <= o_frog_y + TILE_Y;
                    LEFT:    o_frog_x <= o_frog_x - TILE_X;
                    RIGHT:   o_frog_x <= o_frog_x + TILE_X;
                    default: o_frog_x <= o_frog_x;
                endcase
            end
        end
    end

    assign o_draw_frog = i_game_active;

    a_on_grid : assert property (@(posedge i_Clk) disable iff (i_reset)
        (o_frog_x <= X_LAST) && (o_frog_y <= Y_LAST)
        && ((o_frog_x % TILE_X) == 10'd0) && ((o_frog_y % TILE_Y) == 9'd0));

    a_level_up_pulse : assert property (@(posedge i_Clk) disable iff (i_reset)
        o_level_up |=> !o_level_up);

endmodule

`default_nettype wire

/* src/game_control.sv */
/*
 * Game state machine. Starts a game, takes a life on every hit, ends the
 * game when lives run out, and keeps the level count.
 */
`timescale 1ns/1ps
`default_nettype none

`include "frogger_settings.svh"

module game_control
(
    input  wire                       i_Clk,
    input  wire                       i_reset,
    input  wire                       i_start,
    input  wire                       i_hit,
    input  wire                       i_level_up,
    output frogger_pkg::game_state_t  o_state,
    output logic                      o_game_active,
    output logic [1:0]                o_lives,
    output logic [3:0]                o_level
);

    import frogger_pkg::*;

    game_state_t state_q;

    always_ff @(posedge i_Clk)
    begin
        if (i_reset)
        begin
            state_q <= IDLE;
            o_lives <= 2'd0;
            o_level <= 4'd0;
        end
        else
        begin
            case (state_q)
                IDLE:
                begin
                    // New game, full lives and level back to zero
                    if (i_start)
                    begin
                        state_q <= ACTIVE;
                        o_lives <= 2'(`START_LIVES);
                        o_level <= 4'd0;
                    end
                end

                ACTIVE:
                begin
                    if (i_hit)
                    begin
                        o_lives <= o_lives - 2'd1;
                        // Last life gone
                        if (o_lives == 2'd1)
                        begin
                            state_q <= OVER;
                        end
                    end
                    else if (i_level_up)
                    begin
                        o_level <= o_level + 4'd1;
                    end
                end

                OVER:
                begin
                    if (i_start)
                    begin
                        state_q <= IDLE;
                    end
                end

                default:
                begin
                    state_q <= IDLE;
                end
            endcase
        end
    end

    assign o_state       = state_q;
    assign o_game_active = (state_q == ACTIVE);

    // A life can only be lost out of a running game
    a_lives_only_active : assert property (@(posedge i_Clk) disable iff (i_reset)
        (o_lives < $past(o_lives)) |-> ($past(state_q) == ACTIVE));

endmodule

`default_nettype wire

/* src/frogger_pkg.sv */
/*
 * Game state and move direction types shared by the frog game core
 * and its testbench. Import where the enum values are needed.
 */
`default_nettype none

package frogger_pkg;

    // Top level game flow
    typedef enum logic [1:0]
    {
        IDLE   = 2'd0,
        ACTIVE = 2'd1,
        OVER   = 2'd2
    } game_state_t;

    // One decoded button press, NONE when zero or several are held
    typedef enum logic [2:0]
    {
        NONE  = 3'd0,
        UP    = 3'd1,
        DOWN  = 3'd2,
        LEFT  = 3'd3,
        RIGHT = 3'd4
    } move_dir_t;

endpackage

`default_nettype wire

/* src/frogger_settings.svh */
/*
 * Playfield geometry, lane rows and game constants for the frog game.
 * Include in any file that needs sizes or start positions.
 */
`ifndef FROGGER_SETTINGS_SVH
`define FROGGER_SETTINGS_SVH

// Visible playfield in pixels
`define H_VISIBLE     10'd640
`define V_VISIBLE     10'd480

// Square tile, every position is a multiple of this
`define TILE_SIZE     32

// Frog spawn point, bottom row centre
`define FROG_X_BASE   320
`define FROG_Y_BASE   448

// Rows occupied by the two car lanes
`define LANE0_Y       384
`define LANE1_Y       320

`define CARS_PER_LANE 2
`define START_LIVES   3
`define SCORE_W       6

`endif
